/* Bender.yml */
package:
  name: mips_core

sources:
  - include_dirs:
      - include
    files:
      - src/mips_pkg.sv
      - src/mips_fetch_decode.sv
      - src/mips_regfile.sv
      - src/mips_alu.sv
      - src/mips_mem_writeback.sv
      - src/mips_core.sv
  - target: test
    files:
      - verification/mips_core_assertions.sv
      - verification/mips_core_tb.sv

/* include/mips_params.svh */
// shared sizing macros; XLEN other than 32 is not supported by the lane logic
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// data word width in bits
`define MIPS_XLEN 32

// architectural GPR count, $0 included
`define MIPS_NREGS 32

// byte address of the first fetch after reset
`define MIPS_TEXT_START 32'h0040_0000

// $v0 value that turns a syscall into a halt
`define MIPS_SYSCALL_EXIT 10

`endif

/* list.f */
+incdir+include
src/mips_pkg.sv
src/mips_fetch_decode.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_mem_writeback.sv
src/mips_core.sv
verification/mips_core_assertions.sv
verification/mips_core_tb.sv

/* src/mips_alu.sv */
// purely combinational; add and sub wrap silently, no overflow detection
`default_nettype none

`include "mips_params.svh"

module mips_alu import mips_pkg::*; (
   input  wire word_t      rs_data,
   input  wire word_t      rt_data,
   input  wire word_t      imm,
   input  wire logic [4:0] shamt,
   input  wire alu_op_t    alu_op,
   input  wire logic       use_imm,
   output word_t           alu_out
);

   word_t      op_b;
   logic [4:0] var_sh;   // shift amount from rs

   assign op_b   = use_imm ? imm : rt_data;   // imm covers load/store offsets too
   assign var_sh = rs_data[4:0];

   always_comb begin
      case (alu_op)
         ALU_ADD:  alu_out = rs_data + op_b;
         ALU_SUB:  alu_out = rs_data - op_b;
         ALU_AND:  alu_out = rs_data & op_b;
         ALU_OR:   alu_out = rs_data | op_b;
         ALU_XOR:  alu_out = rs_data ^ op_b;
         ALU_NOR:  alu_out = ~(rs_data | op_b);
         // signed compare, slt and slti
         ALU_SLT:  alu_out = ($signed(rs_data) < $signed(op_b)) ? word_t'(1) : '0;
         ALU_SLL:  alu_out = rt_data << shamt;
         ALU_SRL:  alu_out = rt_data >> shamt;
         ALU_SRA:  alu_out = word_t'($signed(rt_data) >>> shamt);   // keeps sign
         ALU_SLLV: alu_out = rt_data << var_sh;
         ALU_SRLV: alu_out = rt_data >> var_sh;
         ALU_SRAV: alu_out = word_t'($signed(rt_data) >>> var_sh);
         ALU_LUI:  alu_out = {imm[15:0], 16'h0000};   // imm in upper half
         default:  alu_out = '0;
      endcase
   end

endmodule

`default_nettype wire

/* src/mips_core.sv */
// single-cycle core; instruction and data memories must answer in the same cycle
`default_nettype none

`include "mips_params.svh"

module mips_core import mips_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst_b,
   input  wire word_t inst,
   input  wire word_t mem_rdata,
   output waddr_t     inst_addr,
   output waddr_t     mem_addr,
   output word_t      mem_wdata,
   output byte_en_t   mem_be,
   output logic       halted
);

   reg_idx_t   rs, rt, wr_idx;
   word_t      imm;
   logic [4:0] shamt;
   alu_op_t    alu_op;
   logic       use_imm;
   mem_kind_t  mem_kind;
   logic       reg_we;
   logic       is_syscall;
   logic       reserved;
   word_t      rs_data, rt_data, v0_data;
   word_t      alu_out;
   word_t      wr_data;   // writeback value

   mips_fetch_decode fd0 (
      .clk(clk), .rst_b(rst_b), .inst(inst), .halted(halted),
      .inst_addr(inst_addr), .rs(rs), .rt(rt), .wr_idx(wr_idx),
      .imm(imm), .shamt(shamt), .alu_op(alu_op), .use_imm(use_imm),
      .mem_kind(mem_kind), .reg_we(reg_we), .is_syscall(is_syscall),
      .reserved(reserved)
   );

   mips_regfile rf0 (
      .clk(clk), .rst_b(rst_b), .rs(rs), .rt(rt), .wr_idx(wr_idx),
      .wr_data(wr_data), .reg_we(reg_we),
      .rs_data(rs_data), .rt_data(rt_data), .v0_data(v0_data)
   );

   mips_alu alu0 (
      .rs_data(rs_data), .rt_data(rt_data), .imm(imm), .shamt(shamt),
      .alu_op(alu_op), .use_imm(use_imm), .alu_out(alu_out)
   );

   mips_mem_writeback mw0 (
      .clk(clk), .rst_b(rst_b), .alu_out(alu_out), .rt_data(rt_data),
      .mem_rdata(mem_rdata), .v0_data(v0_data), .mem_kind(mem_kind),
      .is_syscall(is_syscall), .reserved(reserved),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_be(mem_be),
      .wr_data(wr_data), .halted(halted)
   );

endmodule

`default_nettype wire

/* src/mips_fetch_decode.sv */
// sequential PC only (no branches or jumps); decode is combinational off inst
`default_nettype none

`include "mips_params.svh"

module mips_fetch_decode import mips_pkg::*; (
   input  wire logic      clk,
   input  wire logic      rst_b,
   input  wire word_t     inst,
   input  wire logic      halted,
   output waddr_t         inst_addr,
   output reg_idx_t       rs,
   output reg_idx_t       rt,
   output reg_idx_t       wr_idx,
   output word_t          imm,
   output logic [4:0]     shamt,
   output alu_op_t        alu_op,
   output logic           use_imm,
   output mem_kind_t      mem_kind,
   output logic           reg_we,
   output logic           is_syscall,
   output logic           reserved
);

   word_t     pc;
   opcode_t   op;
   funct_t    fn;
   reg_idx_t  rd;
   logic      dest_rd;      // R-type writes rd, else rt
   logic      zero_ext;     // logical immediates
   logic      writes_reg;   // decoded intent, before gating
   mem_kind_t mem_kind_dec;

   // PC, frozen once halted
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc <= `MIPS_TEXT_START;
      end else if (!halted) begin
         pc <= pc + word_t'(4);
      end
   end

   assign inst_addr = pc[31:2];   // word address

   // field split
   assign op    = opcode_t'(inst[31:26]);
   assign fn    = funct_t'(inst[5:0]);
   assign rs    = inst[25:21];
   assign rt    = inst[20:16];
   assign rd    = inst[15:11];
   assign shamt = inst[10:6];

   assign imm = zero_ext ? {16'h0000, inst[15:0]}
                         : {{16{inst[15]}}, inst[15:0]};

   always_comb begin
      alu_op       = ALU_ADD;
      use_imm      = 1'b0;
      mem_kind_dec = MEM_NONE;
      dest_rd      = 1'b0;
      zero_ext     = 1'b0;
      writes_reg   = 1'b0;
      is_syscall   = 1'b0;
      reserved     = 1'b0;
      case (op)
         OP_SPECIAL: begin
            dest_rd    = 1'b1;
            writes_reg = 1'b1;
            case (fn)
               FN_SLL:           alu_op = ALU_SLL;
               FN_SRL:           alu_op = ALU_SRL;
               FN_SRA:           alu_op = ALU_SRA;
               FN_SLLV:          alu_op = ALU_SLLV;
               FN_SRLV:          alu_op = ALU_SRLV;
               FN_SRAV:          alu_op = ALU_SRAV;
               FN_ADD, FN_ADDU:  alu_op = ALU_ADD;   // no overflow trap
               FN_SUB, FN_SUBU:  alu_op = ALU_SUB;
               FN_AND:           alu_op = ALU_AND;
               FN_OR:            alu_op = ALU_OR;
               FN_XOR:           alu_op = ALU_XOR;
               FN_NOR:           alu_op = ALU_NOR;
               FN_SLT:           alu_op = ALU_SLT;
               FN_SYSCALL: begin
                  is_syscall = 1'b1;
                  writes_reg = 1'b0;
               end
               default: begin
                  reserved   = 1'b1;  // unknown funct
                  writes_reg = 1'b0;
               end
            endcase
         end
         OP_ADDIU: begin
            use_imm    = 1'b1;
            writes_reg = 1'b1;
         end
         OP_SLTI: begin
            alu_op     = ALU_SLT;
            use_imm    = 1'b1;
            writes_reg = 1'b1;
         end
         OP_ANDI, OP_ORI, OP_XORI: begin
            alu_op     = (op == OP_ANDI) ? ALU_AND :
                         (op == OP_ORI)  ? ALU_OR  : ALU_XOR;
            use_imm    = 1'b1;
            zero_ext   = 1'b1;
            writes_reg = 1'b1;
         end
         OP_LUI: begin
            alu_op     = ALU_LUI;
            use_imm    = 1'b1;
            writes_reg = 1'b1;
         end
         OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
            use_imm    = 1'b1;   // rs + offset
            writes_reg = 1'b1;
            case (op)
               OP_LB:   mem_kind_dec = MEM_LB;
               OP_LBU:  mem_kind_dec = MEM_LBU;
               OP_LH:   mem_kind_dec = MEM_LH;
               OP_LHU:  mem_kind_dec = MEM_LHU;
               default: mem_kind_dec = MEM_LW;
            endcase
         end
         OP_SB, OP_SW: begin
            use_imm      = 1'b1;
            mem_kind_dec = (op == OP_SB) ? MEM_SB : MEM_SW;
         end
         default: reserved = 1'b1;   // unknown opcode
      endcase
   end

   assign wr_idx = dest_rd ? rd : rt;

   // no writes once halted, none to $0
   assign reg_we   = writes_reg & ~halted & (wr_idx != '0);
   assign mem_kind = halted ? MEM_NONE : mem_kind_dec;   // kills stores after halt

endmodule

`default_nettype wire

/* src/mips_mem_writeback.sv */
// little-endian lanes; unaligned halfword and word accesses are not trapped
`default_nettype none

`include "mips_params.svh"

module mips_mem_writeback import mips_pkg::*; (
   input  wire logic      clk,
   input  wire logic      rst_b,
   input  wire word_t     alu_out,
   input  wire word_t     rt_data,
   input  wire word_t     mem_rdata,
   input  wire word_t     v0_data,
   input  wire mem_kind_t mem_kind,
   input  wire logic      is_syscall,
   input  wire logic      reserved,
   output waddr_t         mem_addr,
   output word_t          mem_wdata,
   output byte_en_t       mem_be,
   output word_t          wr_data,
   output logic           halted
);

   logic [1:0]  lane;        // byte offset within the word
   logic [7:0]  ld_byte;
   logic [15:0] ld_half;

   assign mem_addr = alu_out[31:2];
   assign lane     = alu_out[1:0];

   // store steering
   always_comb begin
      case (mem_kind)
         MEM_SW: begin
            mem_be    = 4'b1111;
            mem_wdata = rt_data;
         end
         MEM_SB: begin
            mem_be    = 4'b0001 << lane;        // one-hot lane
            mem_wdata = {4{rt_data[7:0]}};      // byte on every lane
         end
         default: begin
            mem_be    = 4'b0000;
            mem_wdata = rt_data;
         end
      endcase
   end

   // load lane pick
   assign ld_byte = mem_rdata[8*lane +: 8];
   assign ld_half = lane[1] ? mem_rdata[31:16] : mem_rdata[15:0];

   always_comb begin
      case (mem_kind)
         MEM_LB:  wr_data = {{24{ld_byte[7]}}, ld_byte};
         MEM_LBU: wr_data = {24'h000000, ld_byte};
         MEM_LH:  wr_data = {{16{ld_half[15]}}, ld_half};
         MEM_LHU: wr_data = {16'h0000, ld_half};
         MEM_LW:  wr_data = mem_rdata;
         default: wr_data = alu_out;   // ALU results
      endcase
   end

   // sticky halt, cleared only by reset
   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halted <= 1'b0;
      end else if (reserved || (is_syscall && v0_data == word_t'(`MIPS_SYSCALL_EXIT))) begin
         halted <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* src/mips_pkg.sv */
// core types only; opcode and funct enums list just the encodings this core executes
`default_nettype none

`include "mips_params.svh"

package mips_pkg;

   typedef logic [`MIPS_XLEN-1:0] word_t;   // one data word
   typedef logic [29:0]           waddr_t;  // word address, byte bits dropped
   typedef logic [4:0]            reg_idx_t;
   typedef logic [3:0]            byte_en_t; // bit n enables byte lane n

   // primary opcodes, inst[31:26]
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LB      = 6'h20,
      OP_LH      = 6'h21,
      OP_LW      = 6'h23,
      OP_LBU     = 6'h24,
      OP_LHU     = 6'h25,
      OP_SB      = 6'h28,
      OP_SW      = 6'h2b
   } opcode_t;

   // SPECIAL function codes, inst[5:0]
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_SLLV    = 6'h04,
      FN_SRLV    = 6'h06,
      FN_SRAV    = 6'h07,
      FN_SYSCALL = 6'h0c,
      FN_ADD     = 6'h20,
      FN_ADDU    = 6'h21,
      FN_SUB     = 6'h22,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
      ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV, ALU_LUI
   } alu_op_t;

   // one field for loads, stores and no access
   typedef enum logic [2:0] {
      MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SW
   } mem_kind_t;

endpackage

`default_nettype wire

/* src/mips_regfile.sv */
// 31 GPRs with async reset; $0 is not stored and always reads zero
`default_nettype none

`include "mips_params.svh"

module mips_regfile import mips_pkg::*; (
   input  wire logic     clk,
   input  wire logic     rst_b,
   input  wire reg_idx_t rs,
   input  wire reg_idx_t rt,
   input  wire reg_idx_t wr_idx,
   input  wire word_t    wr_data,
   input  wire logic     reg_we,
   output word_t         rs_data,
   output word_t         rt_data,
   output word_t         v0_data
);

   localparam reg_idx_t V0 = 5'd2;   // syscall code register

   word_t regs [1:`MIPS_NREGS-1];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 1; i < `MIPS_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 1; i < `MIPS_NREGS; i++) begin
            if (reg_we && wr_idx == reg_idx_t'(i)) begin
               regs[i] <= wr_data;
            end
         end
      end
   end

   // reads are combinational, new value seen next cycle
   assign rs_data = (rs == '0) ? '0 : regs[rs];
   assign rt_data = (rt == '0) ? '0 : regs[rt];
   assign v0_data = regs[V0];

endmodule

`default_nettype wire

/* verification/mips_core_assertions.sv */
// sampled at posedge clk and disabled while rst_b is low
`default_nettype none

module mips_core_assertions import mips_pkg::*; (
   input wire logic     clk,
   input wire logic     rst_b,
   input wire logic     halted,
   input wire waddr_t   inst_addr,
   input wire byte_en_t mem_be
);

   // no store may leave the core once halted
   be_quiet_when_halted: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> mem_be == '0)
      else $error("store enable active while halted");

   // PC frozen from the halt edge on
   pc_frozen: assert property (@(posedge clk) disable iff (!rst_b)
      halted |=> $stable(inst_addr))
      else $error("inst_addr moved while halted");

   // sw, sb or nothing
   be_legal: assert property (@(posedge clk) disable iff (!rst_b)
      (mem_be inside {4'b0000, 4'b1111}) || $onehot(mem_be))
      else $error("mem_be is neither zero, all ones nor one-hot");

endmodule

`default_nettype wire

/* verification/mips_core_tb.sv */
// plays both memories from the tests file, one line per cycle; memories answer in the same cycle
`default_nettype none

module mips_core_tb import mips_pkg::*; ();

   localparam string TESTS_FILE   = "verification/mips_core_tests.txt";
   localparam int    RESET_CYCLES = 8;
   localparam int    PERIOD       = 10;

   logic     clk;
   logic     rst_b;
   word_t    inst;
   word_t    mem_rdata;
   waddr_t   inst_addr;
   waddr_t   mem_addr;
   word_t    mem_wdata;
   byte_en_t mem_be;
   logic     halted;

   // one entry per test line
   string    names[$];
   word_t    t_inst[$];
   word_t    t_rdata[$];
   waddr_t   t_ia[$];
   waddr_t   t_ma[$];
   word_t    t_wdata[$];
   byte_en_t t_be[$];
   logic     t_halt[$];
   int       n_resets;
   int       n_checked;
   longint   limit;     // watchdog time, 0 until the file is read

   mips_core dut0 (
      .clk(clk), .rst_b(rst_b), .inst(inst), .mem_rdata(mem_rdata),
      .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_be(mem_be), .halted(halted)
   );

   bind mips_core mips_core_assertions asrt0 (
      .clk(clk), .rst_b(rst_b), .halted(halted), .inst_addr(inst_addr), .mem_be(mem_be)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   task automatic mismatch(string test, string field, word_t expv, word_t actv);
      $display("FAILED %s: %s expected %h, got %h", test, field, expv, actv);
      $display("Test failures found");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic addr_check(string test, string field, waddr_t expv, waddr_t actv);
      if (actv !== expv) mismatch(test, field, word_t'(expv), word_t'(actv));
   endtask

   task automatic word_check(string test, string field, word_t expv, word_t actv);
      if (actv !== expv) mismatch(test, field, expv, actv);
   endtask

   task automatic be_check(string test, byte_en_t expv, byte_en_t actv);
      if (actv !== expv) mismatch(test, "mem_be", word_t'(expv), word_t'(actv));
   endtask

   task automatic halt_check(string test, logic expv, logic actv);
      if (actv !== expv) mismatch(test, "halted", word_t'(expv), word_t'(actv));
   endtask

   // whole file into the queues before the clock matters
   task automatic read_tests();
      int       fd;
      int       cnt;
      string    line;
      string    name;
      word_t    f_inst, f_rdata, f_wdata;
      waddr_t   f_ia, f_ma;
      byte_en_t f_be;
      logic     f_halt;
      fd = $fopen(TESTS_FILE, "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file %s", TESTS_FILE);
         $display("Test failures found");
         $fatal(1, "no stimulus");
      end else begin
         while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") begin
               // blank or comment line
            end else begin
               cnt = $sscanf(line, "%s %h %h %h %h %h %h %h", name, f_inst, f_rdata,
                             f_ia, f_ma, f_wdata, f_be, f_halt);
               if (cnt != 8) begin
                  $display("malformed line in %s: %s", TESTS_FILE, line);
                  $display("Test failures found");
                  $fatal(1, "bad stimulus file");
               end else begin
                  names.push_back(name);
                  t_inst.push_back(f_inst);
                  t_rdata.push_back(f_rdata);
                  t_ia.push_back(f_ia);
                  t_ma.push_back(f_ma);
                  t_wdata.push_back(f_wdata);
                  t_be.push_back(f_be);
                  t_halt.push_back(f_halt);
                  if (name == "reset") n_resets++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // ends one step after a rising edge, like every line
   task automatic apply_reset();
      rst_b     = 1'b0;
      inst      = '0;   // sll $0,$0,0 acts as nop
      mem_rdata = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      halt_check("reset", 1'b0, halted);
      be_check("reset", '0, mem_be);
      rst_b = 1'b1;
   endtask

   task automatic run_line(int i);
      inst      = t_inst[i];
      mem_rdata = t_rdata[i];
      #5;   // mid-cycle, outputs settled
      addr_check(names[i], "inst_addr", t_ia[i], inst_addr);
      halt_check(names[i], t_halt[i], halted);
      be_check(names[i], t_be[i], mem_be);
      if (t_be[i] != '0) begin   // addr and data only matter for a store
         addr_check(names[i], "mem_addr", t_ma[i], mem_addr);
         word_check(names[i], "mem_wdata", t_wdata[i], mem_wdata);
      end
      n_checked++;
      @(posedge clk);
      #1;
   endtask

   initial begin
      rst_b     = 1'b0;
      inst      = '0;
      mem_rdata = '0;
      n_resets  = 0;
      n_checked = 0;
      limit     = 0;
      read_tests();
      limit = (longint'(names.size()) + RESET_CYCLES * (n_resets + 1) + 20) * PERIOD;
      apply_reset();
      for (int i = 0; i < names.size(); i++) begin
         if (names[i] == "reset") apply_reset();
         else run_line(i);
      end
      if (n_checked == 0) begin
         $display("no test lines were found in %s", TESTS_FILE);
         $display("Test failures found");
         $fatal(1, "empty test list");
      end else begin
         $display("All tests passed!");
         $finish;
      end
   end

   // watchdog, armed once the line count is known
   initial begin
      wait (limit > 0);
      #(limit);
      $display("the tests did not finish within %0d time units", limit);
      $display("Test failures found");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

/* verification/mips_core_tests.txt */
# name inst mem_rdata exp_inst_addr exp_mem_addr exp_mem_wdata exp_mem_be exp_halted (hex)
# a line named reset holds rst_b low for 8 cycles; mem_addr and mem_wdata unchecked when be is 0
ori_t0        34081234 00000000 00100000 00000000 00000000 0 0
addiu_t1      2409fffc 00000000 00100001 00000000 00000000 0 0
sw_addiu      ac090100 00000000 00100002 00000040 fffffffc f 0
addu          01095021 00000000 00100003 00000000 00000000 0 0
sw_addu       ac0a0100 00000000 00100004 00000040 00001230 f 0
subu          01095823 00000000 00100005 00000000 00000000 0 0
sw_subu       ac0b0100 00000000 00100006 00000040 00001238 f 0
nor           01095027 00000000 00100007 00000000 00000000 0 0
sw_nor        ac0a0100 00000000 00100008 00000040 00000003 f 0
slt           0128582a 00000000 00100009 00000000 00000000 0 0
sw_slt        ac0b0100 00000000 0010000a 00000040 00000001 f 0
sra           00095103 00000000 0010000b 00000000 00000000 0 0
sw_sra        ac0a0100 00000000 0010000c 00000040 ffffffff f 0
srlv          01095806 00000000 0010000d 00000000 00000000 0 0
sw_srlv       ac0b0100 00000000 0010000e 00000040 00000fff f 0
ori_r0        34000055 00000000 0010000f 00000000 00000000 0 0
sw_r0         ac000100 00000000 00100010 00000040 00000000 f 0
andi          312a8001 00000000 00100011 00000000 00000000 0 0
sw_andi       ac0a0100 00000000 00100012 00000040 00008000 f 0
lui           3c0bbeef 00000000 00100013 00000000 00000000 0 0
sw_lui        ac0b0100 00000000 00100014 00000040 beef0000 f 0
lb_lane1      800a0101 89abcdef 00100015 00000000 00000000 0 0
sw_lb         ac0a0100 00000000 00100016 00000040 ffffffcd f 0
lbu_lane3     900b0103 89abcdef 00100017 00000000 00000000 0 0
sw_lbu        ac0b0100 00000000 00100018 00000040 00000089 f 0
lh_upper      840a0102 89abcdef 00100019 00000000 00000000 0 0
sw_lh         ac0a0100 00000000 0010001a 00000040 ffff89ab f 0
lhu_lower     940b0100 89abcdef 0010001b 00000000 00000000 0 0
sw_lhu        ac0b0100 00000000 0010001c 00000040 0000cdef f 0
lw            8c0a0104 13579bdf 0010001d 00000000 00000000 0 0
sw_lw         ac0a0100 00000000 0010001e 00000040 13579bdf f 0
sb_lane0      a00a0100 00000000 0010001f 00000040 dfdfdfdf 1 0
sb_lane1      a00a0101 00000000 00100020 00000040 dfdfdfdf 2 0
sb_lane2      a00a0102 00000000 00100021 00000040 dfdfdfdf 4 0
sb_lane3      a00a0103 00000000 00100022 00000040 dfdfdfdf 8 0
v0_is_5       24020005 00000000 00100023 00000000 00000000 0 0
syscall_run   0000000c 00000000 00100024 00000000 00000000 0 0
v0_is_10      2402000a 00000000 00100025 00000000 00000000 0 0
syscall_halt  0000000c 00000000 00100026 00000000 00000000 0 0
halted_sw     ac0a0100 00000000 00100027 00000000 00000000 0 1
halted_addiu  240a0001 00000000 00100027 00000000 00000000 0 1
reset         00000000 00000000 00000000 00000000 00000000 0 0
addiu_t0      24080007 00000000 00100000 00000000 00000000 0 0
reserved_op   fc000000 00000000 00100001 00000000 00000000 0 0
rsv_halt_sw   ac080100 00000000 00100002 00000000 00000000 0 1
rsv_frozen    ac080100 00000000 00100002 00000000 00000000 0 1
